// ==== compile.f ====
+incdir+logic
logic/pipeline_pkg.sv
logic/pipeline_if.sv
logic/decode_stage.sv
logic/register_file.sv
logic/operand_stage.sv
logic/execute_stage.sv
logic/writeback_stage.sv
logic/pipeline.sv
testbench/tb_pipeline.sv

// ==== logic/decode_stage.sv ====
`timescale 1ns/1ps
`include "pipeline_params.svh"

module decode_stage (
   input  logic                  clk,
   input  logic                  rst_n,
   input  pipeline_pkg::instr_t  instr,
   input  logic                  instr_valid,
   output logic                  instr_ready,
   decoded_if.decode             de
);
   import pipeline_pkg::*;

   logic halt_seen;
   logic accept;

   // No new work once a halt is in, and none while the operand stage stalls
   assign instr_ready = !halt_seen && !de.stall;
   assign accept      = instr_valid && instr_ready;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         de.valid  <= 1'b0;
         halt_seen <= 1'b0;
      end else begin
         // Hold the latch on stall, else take the new word or go empty
         if (!de.stall) begin
            de.valid <= accept;
         end
         if (accept && instr[`HALT_BIT]) begin
            halt_seen <= 1'b1;
         end
      end
   end

   // Field split of the accepted word
   always_ff @(posedge clk) begin
      if (accept) begin
         de.op      <= alu_op_t'(instr[`OP_LSB +: `ALU_OP_W]);
         de.use_imm <= instr[`USE_IMM_BIT];
         de.halt    <= instr[`HALT_BIT];
         de.dr      <= instr[`DR_LSB +: `REG_ID_W];
         de.sr1     <= instr[`SR1_LSB +: `REG_ID_W];
         de.sr2     <= instr[`SR2_LSB +: `REG_ID_W];
         de.imm     <= instr[`IMM_LSB +: `IMM_W];
      end
   end

endmodule

// ==== logic/execute_stage.sv ====
`timescale 1ns/1ps
`include "pipeline_params.svh"

module execute_stage (
   input  logic    clk,
   input  logic    rst_n,
   stage_if.sink   ex,
   stage_if.source wb
);
   import pipeline_pkg::*;

   data_t              result;
   logic [`SHAMT_W-1:0] shamt;

   // Shift count from the low bits of b
   assign shamt = ex.b[`SHAMT_W-1:0];

   always_comb begin
      case (ex.op)
         alu_add:    result = ex.a + ex.b;
         alu_sub:    result = ex.a - ex.b;
         alu_and:    result = ex.a & ex.b;
         alu_or:     result = ex.a | ex.b;
         alu_xor:    result = ex.a ^ ex.b;
         alu_shl:    result = ex.a << shamt;
         alu_shr:    result = ex.a >> shamt;
         alu_pass_b: result = ex.b;
         default:    result = ex.b;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wb.valid  <= 1'b0;
         wb.ld_gpr <= 1'b0;
      end else begin
         wb.valid  <= ex.valid;
         wb.ld_gpr <= ex.valid && ex.ld_gpr;
      end
   end

   // Result rides in a
   always_ff @(posedge clk) begin
      if (ex.valid) begin
         wb.op <= ex.op;
         wb.dr <= ex.dr;
         wb.a  <= result;
      end
   end

   // Second operand has no use past execute
   assign wb.b = '0;

endmodule

// ==== logic/operand_stage.sv ====
`timescale 1ns/1ps
`include "pipeline_params.svh"

module operand_stage (
   input  logic                  clk,
   input  logic                  rst_n,
   decoded_if.operand            de,
   output pipeline_pkg::reg_id_t rd_id1,
   output pipeline_pkg::reg_id_t rd_id2,
   input  pipeline_pkg::data_t   rd_data1,
   input  pipeline_pkg::data_t   rd_data2,
   stage_if.source               ex,
   stage_if.observe              wb_obs
);
   import pipeline_pkg::*;

   logic  ex_writes;
   logic  wb_writes;
   logic  sr1_busy;
   logic  sr2_busy;
   logic  issue;
   data_t imm_ext;
   data_t b_sel;

   // True when a pending writer targets the given register
   function automatic logic pending_write(input reg_id_t id,
                                          input logic ex_w, input reg_id_t ex_dr,
                                          input logic wb_w, input reg_id_t wb_dr);
      logic hit;
      hit = (ex_w && (ex_dr == id)) || (wb_w && (wb_dr == id));
      return hit;
   endfunction

   assign rd_id1 = de.sr1;
   assign rd_id2 = de.sr2;

   // Zero extended immediate replaces the second source
   assign imm_ext = {{(`DATA_W - `IMM_W){1'b0}}, de.imm};
   assign b_sel   = de.use_imm ? imm_ext : rd_data2;

   // Writers still in flight
   assign ex_writes = ex.valid && ex.ld_gpr;
   assign wb_writes = wb_obs.valid && wb_obs.ld_gpr;

   assign sr1_busy = pending_write(de.sr1, ex_writes, ex.dr, wb_writes, wb_obs.dr);

   // Second source only counts when no immediate is used
   assign sr2_busy = !de.use_imm &&
                     pending_write(de.sr2, ex_writes, ex.dr, wb_writes, wb_obs.dr);

   assign de.stall = de.valid && (sr1_busy || sr2_busy);
   assign issue    = de.valid && !de.stall;

   // Execute latch control, a bubble goes in while stalling
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ex.valid  <= 1'b0;
         ex.ld_gpr <= 1'b0;
      end else begin
         ex.valid  <= issue;
         ex.ld_gpr <= issue && !de.halt;
      end
   end

   // Operand payload
   always_ff @(posedge clk) begin
      if (issue) begin
         ex.op <= de.op;
         ex.dr <= de.dr;
         ex.a  <= rd_data1;
         ex.b  <= b_sel;
      end
   end

endmodule

// ==== logic/pipeline.sv ====
`timescale 1ns/1ps

module pipeline (
   input  logic                  clk,
   input  logic                  rst_n,
   input  pipeline_pkg::instr_t  instr,
   input  logic                  instr_valid,
   output logic                  instr_ready,
   output logic                  wb_valid,
   output pipeline_pkg::reg_id_t wb_dr,
   output pipeline_pkg::data_t   wb_data,
   output logic                  halted
);
   import pipeline_pkg::*;

   // Register file ports
   reg_id_t rd_id1;
   reg_id_t rd_id2;
   data_t   rd_data1;
   data_t   rd_data2;
   logic    wr_en;
   reg_id_t wr_id;
   data_t   wr_data;

   // Stage latches
   decoded_if de_if ();
   stage_if   ex_if ();
   stage_if   wb_if ();

   decode_stage u_decode_stage (
      .clk         (clk),
      .rst_n       (rst_n),
      .instr       (instr),
      .instr_valid (instr_valid),
      .instr_ready (instr_ready),
      .de          (de_if.decode)
   );

   register_file u_register_file (
      .clk      (clk),
      .rst_n    (rst_n),
      .rd_id1   (rd_id1),
      .rd_id2   (rd_id2),
      .rd_data1 (rd_data1),
      .rd_data2 (rd_data2),
      .wr_en    (wr_en),
      .wr_id    (wr_id),
      .wr_data  (wr_data)
   );

   operand_stage u_operand_stage (
      .clk      (clk),
      .rst_n    (rst_n),
      .de       (de_if.operand),
      .rd_id1   (rd_id1),
      .rd_id2   (rd_id2),
      .rd_data1 (rd_data1),
      .rd_data2 (rd_data2),
      .ex       (ex_if.source),
      .wb_obs   (wb_if.observe)
   );

   execute_stage u_execute_stage (
      .clk   (clk),
      .rst_n (rst_n),
      .ex    (ex_if.sink),
      .wb    (wb_if.source)
   );

   writeback_stage u_writeback_stage (
      .clk      (clk),
      .rst_n    (rst_n),
      .wb       (wb_if.sink),
      .wr_en    (wr_en),
      .wr_id    (wr_id),
      .wr_data  (wr_data),
      .wb_valid (wb_valid),
      .wb_dr    (wb_dr),
      .wb_data  (wb_data),
      .halted   (halted)
   );

endmodule

// ==== logic/pipeline_if.sv ====
`timescale 1ns/1ps

// Decode latch contents, stall comes back from the operand stage
interface decoded_if;
   import pipeline_pkg::*;

   logic    valid;
   alu_op_t op;
   logic    use_imm;
   logic    halt;
   reg_id_t dr;
   reg_id_t sr1;
   reg_id_t sr2;
   imm_t    imm;
   logic    stall;

   modport decode (
      output valid, op, use_imm, halt, dr, sr1, sr2, imm,
      input  stall
   );

   modport operand (
      input  valid, op, use_imm, halt, dr, sr1, sr2, imm,
      output stall
   );
endinterface

// Pipeline latch between two later stages
interface stage_if;
   import pipeline_pkg::*;

   logic    valid;
   logic    ld_gpr;
   alu_op_t op;
   reg_id_t dr;
   data_t   a;
   data_t   b;

   modport source (output valid, ld_gpr, op, dr, a, b);

   modport sink (input valid, ld_gpr, op, dr, a, b);

   // Dependency check view of a latch
   modport observe (input valid, ld_gpr, dr);
endinterface

// ==== logic/pipeline_params.svh ====
`ifndef PIPELINE_PARAMS_SVH
`define PIPELINE_PARAMS_SVH

// Datapath widths
`define DATA_W    32
`define IMM_W     16
`define INSTR_W   32

// Register file size and register number width
`define GPR_COUNT 8
`define REG_ID_W  3

// ALU operation code and shift amount
`define ALU_OP_W  3
`define SHAMT_W   5

// Low bit of each instruction field
`define OP_LSB      29
`define USE_IMM_BIT 28
`define HALT_BIT    27
`define DR_LSB      24
`define SR1_LSB     21
`define SR2_LSB     18
`define IMM_LSB     0

`endif

// ==== logic/pipeline_pkg.sv ====
`include "pipeline_params.svh"

package pipeline_pkg;

   // One general register value
   typedef logic [`DATA_W-1:0] data_t;

   // Register number, eight general registers
   typedef logic [`REG_ID_W-1:0] reg_id_t;

   // Immediate field before zero extension
   typedef logic [`IMM_W-1:0] imm_t;

   // Fixed format instruction word
   typedef logic [`INSTR_W-1:0] instr_t;

   // ALU operations, encoded as bits 31..29 of the instruction
   typedef enum logic [`ALU_OP_W-1:0] {
      alu_add    = 3'd0,
      alu_sub    = 3'd1,
      alu_and    = 3'd2,
      alu_or     = 3'd3,
      alu_xor    = 3'd4,
      alu_shl    = 3'd5,
      alu_shr    = 3'd6,
      alu_pass_b = 3'd7
   } alu_op_t;

endpackage

// ==== logic/register_file.sv ====
`timescale 1ns/1ps
`include "pipeline_params.svh"

module register_file (
   input  logic                  clk,
   input  logic                  rst_n,
   input  pipeline_pkg::reg_id_t rd_id1,
   input  pipeline_pkg::reg_id_t rd_id2,
   output pipeline_pkg::data_t   rd_data1,
   output pipeline_pkg::data_t   rd_data2,
   input  logic                  wr_en,
   input  pipeline_pkg::reg_id_t wr_id,
   input  pipeline_pkg::data_t   wr_data
);
   import pipeline_pkg::*;

   data_t gpr [`GPR_COUNT];

   // Single write port from writeback
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         gpr <= '{default: '0};
      end else if (wr_en) begin
         gpr[wr_id] <= wr_data;
      end
   end

   // Combinational reads, no bypass since dependents stall until the write is done
   assign rd_data1 = gpr[rd_id1];
   assign rd_data2 = gpr[rd_id2];

endmodule

// ==== logic/writeback_stage.sv ====
`timescale 1ns/1ps

module writeback_stage (
   input  logic                  clk,
   input  logic                  rst_n,
   stage_if.sink                 wb,
   output logic                  wr_en,
   output pipeline_pkg::reg_id_t wr_id,
   output pipeline_pkg::data_t   wr_data,
   output logic                  wb_valid,
   output pipeline_pkg::reg_id_t wb_dr,
   output pipeline_pkg::data_t   wb_data,
   output logic                  halted
);
   logic halt_entry;
   logic halt_flag;

   // Register write from a valid loading entry
   assign wr_en   = wb.valid && wb.ld_gpr;
   assign wr_id   = wb.dr;
   assign wr_data = wb.a;

   // Completion report
   assign wb_valid = wr_en;
   assign wb_dr    = wb.dr;
   assign wb_data  = wb.a;

   // Only a halt travels valid without ld_gpr
   assign halt_entry = wb.valid && !wb.ld_gpr;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         halt_flag <= 1'b0;
      end else if (halt_entry) begin
         halt_flag <= 1'b1;
      end
   end

   // Up in the cycle the halt sits here, then sticky
   assign halted = halt_flag || halt_entry;

endmodule

// ==== testbench/tb_pipeline.sv ====
`timescale 1ns/1ps

module tb_pipeline;
   import pipeline_pkg::*;

   localparam int CLK_PERIOD = 20;
   // Instructions offered by all tests together
   localparam int NUM_INSTR  = 78;
   localparam int TIMEOUT_NS = NUM_INSTR * 8 * CLK_PERIOD + 2000;

   logic    clk;
   logic    rst_n;
   instr_t  instr;
   logic    instr_valid;
   logic    instr_ready;
   logic    wb_valid;
   reg_id_t wb_dr;
   data_t   wb_data;
   logic    halted;

   // Register model and expected writebacks in acceptance order
   data_t   model_gpr [8];
   reg_id_t exp_dr [$];
   data_t   exp_data [$];
   int      exp_total;
   int      check_errors;
   int      other_errors;
   int      wb_count;

   pipeline dut (
      .clk         (clk),
      .rst_n       (rst_n),
      .instr       (instr),
      .instr_valid (instr_valid),
      .instr_ready (instr_ready),
      .wb_valid    (wb_valid),
      .wb_dr       (wb_dr),
      .wb_data     (wb_data),
      .halted      (halted)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   task automatic check_data(input data_t got, input data_t exp, input string what);
      if (got !== exp) begin
         check_errors++;
         $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_reg_id(input reg_id_t got, input reg_id_t exp, input string what);
      if (got !== exp) begin
         check_errors++;
         $display("CHECK FAILED at %0t ns: %s is r%0d, expected r%0d", $time, what, got, exp);
      end
   endtask

   task automatic check_bit(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         check_errors++;
         $display("CHECK FAILED at %0t ns: %s is %b, expected %b", $time, what, got, exp);
      end
   endtask

   // Packs op, use_imm, halt, dr, sr1, sr2, two unused bits and imm
   function automatic instr_t make_instr(input alu_op_t op, input logic use_imm,
                                         input logic halt, input reg_id_t dr,
                                         input reg_id_t sr1, input reg_id_t sr2,
                                         input imm_t imm);
      return {op, use_imm, halt, dr, sr1, sr2, 2'b00, imm};
   endfunction

   // Executes one accepted word on the model
   task automatic model_accept(input instr_t w);
      alu_op_t op;
      reg_id_t dr;
      data_t   a;
      data_t   b;
      data_t   res;
      op = alu_op_t'(w[31:29]);
      dr = w[26:24];
      a  = model_gpr[w[23:21]];
      if (w[28]) begin
         b = {16'h0000, w[15:0]};
      end else begin
         b = model_gpr[w[20:18]];
      end
      case (op)
         alu_add: res = a + b;
         alu_sub: res = a - b;
         alu_and: res = a & b;
         alu_or:  res = a | b;
         alu_xor: res = a ^ b;
         alu_shl: res = a << b[4:0];
         alu_shr: res = a >> b[4:0];
         default: res = b;
      endcase
      // Halt writes nothing
      if (!w[27]) begin
         model_gpr[dr] = res;
         exp_dr.push_back(dr);
         exp_data.push_back(res);
         exp_total++;
      end
   endtask

   // Starts on a falling edge and returns on the falling edge after acceptance
   task automatic send(input instr_t w);
      instr       = w;
      instr_valid = 1'b1;
      while (!instr_ready) begin
         @(negedge clk);
      end
      model_accept(w);
      @(negedge clk);
   endtask

   task automatic idle(input int n);
      instr_valid = 1'b0;
      repeat (n) @(negedge clk);
   endtask

   task automatic wait_drain();
      instr_valid = 1'b0;
      while (exp_dr.size() != 0) begin
         @(negedge clk);
      end
      repeat (2) @(negedge clk);
   endtask

   // Writeback monitor on the falling edge where outputs are settled
   always @(negedge clk) begin
      if (rst_n && wb_valid) begin
         wb_count++;
         if (exp_dr.size() == 0) begin
            other_errors++;
            $display("Writeback to r%0d at %0t ns with no instruction outstanding",
                     wb_dr, $time);
         end else begin
            check_reg_id(wb_dr, exp_dr.pop_front(), "wb_dr");
            check_data(wb_data, exp_data.pop_front(), "wb_data");
         end
      end
   end

   task automatic test_reset();
      check_bit(wb_valid, 1'b0, "wb_valid after reset");
      check_bit(halted, 1'b0, "halted after reset");
      check_bit(instr_ready, 1'b1, "instr_ready after reset");
   endtask

   task automatic test_imm_loads();
      for (int i = 0; i < 8; i++) begin
         send(make_instr(alu_pass_b, 1'b1, 1'b0, reg_id_t'(i), 3'd0, 3'd0,
                         imm_t'(16'hf000 + i * 16'h0101)));
      end
      wait_drain();
   endtask

   // Each word reads the one before, all eight operations
   task automatic test_chain();
      send(make_instr(alu_pass_b, 1'b1, 1'b0, 3'd1, 3'd0, 3'd0, 16'h0013));
      send(make_instr(alu_add,    1'b0, 1'b0, 3'd2, 3'd1, 3'd1, 16'h0000));
      send(make_instr(alu_sub,    1'b1, 1'b0, 3'd3, 3'd2, 3'd0, 16'h0001));
      send(make_instr(alu_and,    1'b1, 1'b0, 3'd4, 3'd3, 3'd0, 16'h00f5));
      send(make_instr(alu_or,     1'b1, 1'b0, 3'd5, 3'd4, 3'd0, 16'h1200));
      send(make_instr(alu_xor,    1'b1, 1'b0, 3'd6, 3'd5, 3'd0, 16'hffff));
      send(make_instr(alu_shl,    1'b1, 1'b0, 3'd7, 3'd6, 3'd0, 16'h0024));
      send(make_instr(alu_shr,    1'b0, 1'b0, 3'd0, 3'd7, 3'd4, 16'h0000));
      send(make_instr(alu_pass_b, 1'b0, 1'b0, 3'd1, 3'd3, 3'd0, 16'h0000));
      wait_drain();
   endtask

   task automatic test_stream();
      int start;
      start = wb_count;
      for (int i = 0; i < 16; i++) begin
         send(make_instr(alu_op_t'(i % 8), 1'b1, 1'b0, reg_id_t'(i % 8),
                         reg_id_t'((i + 4) % 8), 3'd0, imm_t'(i * 16'h0123 + 16'h0007)));
      end
      wait_drain();
      check_data(data_t'(wb_count - start), 32'd16, "stream writeback count");
   endtask

   task automatic test_random();
      for (int i = 0; i < 40; i++) begin
         send(make_instr(alu_op_t'($urandom % 8), 1'($urandom % 2), 1'b0,
                         reg_id_t'($urandom % 8), reg_id_t'($urandom % 8),
                         reg_id_t'($urandom % 8), imm_t'($urandom)));
         idle($urandom % 3);
      end
      wait_drain();
   endtask

   task automatic test_halt();
      send(make_instr(alu_pass_b, 1'b1, 1'b0, 3'd2, 3'd0, 3'd0, 16'h0042));
      send(make_instr(alu_add,    1'b0, 1'b0, 3'd3, 3'd2, 3'd2, 16'h0000));
      send(make_instr(alu_xor,    1'b1, 1'b0, 3'd4, 3'd3, 3'd0, 16'h5a5a));
      send(make_instr(alu_sub,    1'b0, 1'b0, 3'd5, 3'd4, 3'd2, 16'h0000));
      send(make_instr(alu_add,    1'b0, 1'b1, 3'd6, 3'd0, 3'd0, 16'h0000));
      // Further offers stay valid and must be refused
      instr       = make_instr(alu_pass_b, 1'b1, 1'b0, 3'd7, 3'd0, 3'd0, 16'hdead);
      instr_valid = 1'b1;
      while (!halted) begin
         check_bit(instr_ready, 1'b0, "instr_ready after halt");
         @(negedge clk);
      end
      repeat (8) begin
         check_bit(instr_ready, 1'b0, "instr_ready while halted");
         check_bit(halted, 1'b1, "halted");
         @(negedge clk);
      end
      // Writeback count is settled at the rising edge
      @(posedge clk);
      check_data(data_t'(wb_count), data_t'(exp_total), "total writebacks");
   endtask

   // Watchdog
   initial begin
      #(TIMEOUT_NS);
      $display("Timeout after %0d ns, the pipeline stopped making progress", TIMEOUT_NS);
      $display("Simulation failed");
      $finish;
   end

   initial begin
      void'($urandom(32'h16a6979a));
      clk          = 1'b0;
      rst_n        = 1'b0;
      instr        = '0;
      instr_valid  = 1'b0;
      check_errors = 0;
      other_errors = 0;
      wb_count     = 0;
      exp_total    = 0;
      foreach (model_gpr[i]) begin
         model_gpr[i] = '0;
      end
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      test_reset();
      test_imm_loads();
      test_chain();
      test_stream();
      test_random();
      test_halt();
      if (exp_dr.size() != 0) begin
         other_errors++;
         $display("%0d expected writebacks never arrived", exp_dr.size());
      end
      $display("Errors: %0d value checks failed, %0d other failures",
               check_errors, other_errors);
      if (check_errors == 0 && other_errors == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule
